// ==== rtl/cpu_pkg.sv ====
// cpu_pkg: shared types and constants of the 8-bit accumulator core
// bus and control structs, state, opcode, addressing and ALU encodings
`default_nettype none

package cpu_pkg;

	localparam logic [15:0] RESET_VECTOR = 16'hfffe; // high byte of the start address

	// positions in CC
	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_C = 0;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        we;
		logic        re;
	} cpu_bus_t;

	typedef enum logic [3:0] {
		VEC_HI,
		VEC_LO,
		FETCH,
		DECODE,
		ARG_HI,
		ARG_LO,
		MEM_READ,
		EXECUTE,
		MEM_WRITE,
		BRANCH,
		PUSH_LO,
		PUSH_HI,
		PULL_HI,
		PULL_LO
	} seq_state_e;

	typedef enum logic [7:0] {
		OP_LDA_IMM  = 8'h86, OP_LDB_IMM  = 8'hc6, OP_LDA_EXT  = 8'hb6, OP_LDB_EXT  = 8'hf6,
		OP_ADDA_IMM = 8'h8b, OP_ADDB_IMM = 8'hcb, OP_ADDA_EXT = 8'hbb, OP_ADDB_EXT = 8'hfb,
		OP_SUBA_IMM = 8'h80, OP_SUBB_IMM = 8'hc0, OP_SUBA_EXT = 8'hb0, OP_SUBB_EXT = 8'hf0,
		OP_ANDA_IMM = 8'h84, OP_ANDB_IMM = 8'hc4, OP_ANDA_EXT = 8'hb4, OP_ANDB_EXT = 8'hf4,
		OP_EORA_IMM = 8'h88, OP_EORB_IMM = 8'hc8, OP_EORA_EXT = 8'hb8, OP_EORB_EXT = 8'hf8,
		OP_STA_EXT  = 8'hb7, OP_STB_EXT  = 8'hf7,
		OP_BRA      = 8'h20, OP_BNE      = 8'h26, OP_BEQ      = 8'h27,
		OP_JMP      = 8'h7e, OP_JSR      = 8'hbd, OP_RTS      = 8'h39, OP_NOP = 8'h12
	} opcode_e;

	typedef enum logic [1:0] {
		AM_INHERENT,
		AM_IMMEDIATE,
		AM_EXTENDED,
		AM_RELATIVE // 8-bit signed offset
	} addr_mode_e;

	typedef enum logic [2:0] {
		ALU_LOAD,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_EOR,
		ALU_PASS
	} alu_op_e;

	typedef struct packed {
		addr_mode_e mode;
		alu_op_e    alu_op;
		logic       acc_b;        // set selects accumulator B
		logic       reads_mem;
		logic       writes_acc;
		logic       is_store;
		logic       is_branch;
		logic       branch_taken;
		logic       is_jmp;
		logic       is_jsr;
		logic       is_rts;
		logic       known;
	} dec_ctl_t;

	typedef struct packed {
		logic acc_write;
		logic flag_write;
		logic pc_inc;
		logic pc_load;
		logic s_dec;
		logic s_inc;
	} reg_ctl_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_alu.sv ====
// cpu_alu: 8-bit load, add, subtract, and, exclusive-or and pass
// result plus updated N, Z, V and C
`timescale 1ns/1ps
`default_nettype none

module cpu_alu
	import cpu_pkg::*;
(
	input  wire alu_op_e op_i,
	input  wire [7:0]    acc_i,
	input  wire [7:0]    operand_i,
	input  wire [7:0]    cc_i,
	output logic [7:0]   result_o,
	output logic [7:0]   cc_o
);

	logic [8:0] sum;
	logic [8:0] diff;
	logic       v_flag;
	logic       c_flag;

	assign sum = {1'b0, acc_i} + {1'b0, operand_i};
	assign diff = {1'b0, acc_i} - {1'b0, operand_i}; // bit 8 is the borrow

	always_comb
	begin
		result_o = acc_i;
		v_flag = 1'b0;
		c_flag = cc_i[FLAG_C]; // logic ops keep carry
		case (op_i)
			ALU_LOAD: result_o = operand_i;
			ALU_ADD:
			begin
				result_o = sum[7:0];
				c_flag = sum[8];
				v_flag = (acc_i[7] == operand_i[7]) && (sum[7] != acc_i[7]);
			end
			ALU_SUB:
			begin
				result_o = diff[7:0];
				c_flag = diff[8];
				v_flag = (acc_i[7] != operand_i[7]) && (diff[7] != acc_i[7]);
			end
			ALU_AND: result_o = acc_i & operand_i;
			ALU_EOR: result_o = acc_i ^ operand_i;
			ALU_PASS: result_o = acc_i; // store data path
			default: result_o = acc_i;
		endcase
	end

	always_comb
	begin
		cc_o = cc_i;
		cc_o[FLAG_N] = result_o[7];
		cc_o[FLAG_Z] = (result_o == 8'h00);
		cc_o[FLAG_V] = v_flag;
		cc_o[FLAG_C] = c_flag;
	end

endmodule

`default_nettype wire

// ==== rtl/cpu_decoder.sv ====
// cpu_decoder: opcode to control struct, plus the branch condition test
`timescale 1ns/1ps
`default_nettype none

module cpu_decoder
	import cpu_pkg::*;
(
	input  wire [7:0] opcode_i,
	input  wire [7:0] cc_i,
	output dec_ctl_t  ctl_o
);

	logic alu_group;

	always_comb
	begin
		ctl_o = '0;
		ctl_o.mode = AM_INHERENT;
		ctl_o.alu_op = ALU_PASS;
		ctl_o.acc_b = opcode_i[6]; // B forms sit in the upper half
		alu_group = 1'b0;
		case (opcode_i)
			OP_LDA_IMM, OP_LDB_IMM, OP_LDA_EXT, OP_LDB_EXT:
			begin
				alu_group = 1'b1;
				ctl_o.alu_op = ALU_LOAD;
			end
			OP_ADDA_IMM, OP_ADDB_IMM, OP_ADDA_EXT, OP_ADDB_EXT:
			begin
				alu_group = 1'b1;
				ctl_o.alu_op = ALU_ADD;
			end
			OP_SUBA_IMM, OP_SUBB_IMM, OP_SUBA_EXT, OP_SUBB_EXT:
			begin
				alu_group = 1'b1;
				ctl_o.alu_op = ALU_SUB;
			end
			OP_ANDA_IMM, OP_ANDB_IMM, OP_ANDA_EXT, OP_ANDB_EXT:
			begin
				alu_group = 1'b1;
				ctl_o.alu_op = ALU_AND;
			end
			OP_EORA_IMM, OP_EORB_IMM, OP_EORA_EXT, OP_EORB_EXT:
			begin
				alu_group = 1'b1;
				ctl_o.alu_op = ALU_EOR;
			end
			OP_STA_EXT, OP_STB_EXT:
			begin
				ctl_o.mode = AM_EXTENDED;
				ctl_o.is_store = 1'b1;
				ctl_o.known = 1'b1;
			end
			OP_BRA, OP_BEQ, OP_BNE:
			begin
				ctl_o.mode = AM_RELATIVE;
				ctl_o.is_branch = 1'b1;
				ctl_o.known = 1'b1;
			end
			OP_JMP:
			begin
				ctl_o.mode = AM_EXTENDED;
				ctl_o.is_jmp = 1'b1;
				ctl_o.known = 1'b1;
			end
			OP_JSR:
			begin
				ctl_o.mode = AM_EXTENDED;
				ctl_o.is_jsr = 1'b1;
				ctl_o.known = 1'b1;
			end
			OP_RTS:
			begin
				ctl_o.is_rts = 1'b1;
				ctl_o.known = 1'b1;
			end
			OP_NOP: ctl_o.known = 1'b1;
			default: ctl_o.known = 1'b0; // skipped by the sequencer
		endcase

		// bit 4 tells extended from immediate in the ALU rows
		if (alu_group)
		begin
			ctl_o.mode = opcode_i[4] ? AM_EXTENDED : AM_IMMEDIATE;
			ctl_o.reads_mem = opcode_i[4];
			ctl_o.writes_acc = 1'b1;
			ctl_o.known = 1'b1;
		end

		case (opcode_i)
			OP_BRA: ctl_o.branch_taken = 1'b1;
			OP_BEQ: ctl_o.branch_taken = cc_i[FLAG_Z];
			OP_BNE: ctl_o.branch_taken = !cc_i[FLAG_Z];
			default: ctl_o.branch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/cpu_regfile.sv ====
// cpu_regfile: A, B, CC, PC and S
// commits the writes, increments and loads the sequencer orders
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile
	import cpu_pkg::*;
#(
	parameter logic [15:0] STACK_INIT = 16'h0200
)
(
	input  wire           cpu_clk_i,
	input  wire           k_reset_i,
	input  wire reg_ctl_t ctl_i,
	input  wire           acc_sel_i,
	input  wire [7:0]     alu_result_i,
	input  wire [7:0]     alu_cc_i,
	input  wire [15:0]    new_pc_i,
	output logic [7:0]    acc_o,
	output logic [7:0]    cc_o,
	output logic [15:0]   pc_o,
	output logic [15:0]   s_o
);

	logic [7:0]  a_q;
	logic [7:0]  b_q;
	logic [7:0]  cc_q;
	logic [15:0] pc_q;
	logic [15:0] s_q;

	always_ff @(posedge cpu_clk_i or posedge k_reset_i)
	begin
		if (k_reset_i)
		begin
			a_q <= 8'h00;
			b_q <= 8'h00;
			cc_q <= 8'h00;
			pc_q <= 16'h0000; // replaced from the reset vector
			s_q <= STACK_INIT;
		end
		else
		begin
			if (ctl_i.acc_write)
			begin
				if (acc_sel_i)
					b_q <= alu_result_i;
				else
					a_q <= alu_result_i;
			end
			if (ctl_i.flag_write)
				cc_q <= alu_cc_i;
			if (ctl_i.pc_load)
				pc_q <= new_pc_i; // load wins over increment
			else if (ctl_i.pc_inc)
				pc_q <= pc_q + 16'h1;
			if (ctl_i.s_dec)
				s_q <= s_q - 16'h1; // stack grows down
			else if (ctl_i.s_inc)
				s_q <= s_q + 16'h1;
		end
	end

	assign acc_o = acc_sel_i ? b_q : a_q;
	assign cc_o = cc_q;
	assign pc_o = pc_q;
	assign s_o = s_q;

endmodule

`default_nettype wire

// ==== rtl/cpu_sequencer.sv ====
// cpu_sequencer: main FSM of the core
// three-phase byte transfers for fetch, operands, data and the stack
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer
	import cpu_pkg::*;
(
	input  wire           cpu_clk_i,
	input  wire           k_reset_i,
	input  wire [7:0]     data_i,
	input  wire dec_ctl_t dec_i,
	input  wire [7:0]     acc_i,
	input  wire [7:0]     alu_result_i,
	input  wire [15:0]    pc_i,
	input  wire [15:0]    s_i,
	output logic [7:0]    opcode_o,
	output logic [7:0]    operand_o,
	output reg_ctl_t      reg_ctl_o,
	output logic [15:0]   new_pc_o,
	output cpu_bus_t      bus_o
);

	seq_state_e  state_q;
	seq_state_e  state_d;
	logic [1:0]  phase_q;       // 0 address, 1 strobe, 2 data
	logic [15:0] addr_q;
	logic        re_q;
	logic        we_q;
	logic [7:0]  wdata_q;
	logic [7:0]  opcode_q;
	logic [7:0]  operand_q;
	logic [7:0]  ea_hi_q;       // also vector and return address high byte
	logic [7:0]  ea_lo_q;
	logic        bus_state;
	logic        bus_write;
	logic        first_phase;
	logic        xfer_done;
	logic [15:0] xfer_addr;
	logic [7:0]  xfer_wdata;

	// what the current state moves on the bus
	always_comb
	begin
		bus_state = 1'b1;
		bus_write = 1'b0;
		xfer_addr = pc_i; // fetch and operand bytes
		xfer_wdata = acc_i;
		case (state_q)
			VEC_HI: xfer_addr = RESET_VECTOR;
			VEC_LO: xfer_addr = RESET_VECTOR + 16'h1;
			MEM_READ: xfer_addr = {ea_hi_q, ea_lo_q};
			MEM_WRITE:
			begin
				xfer_addr = {ea_hi_q, ea_lo_q};
				bus_write = 1'b1;
				xfer_wdata = alu_result_i; // store data through the ALU pass
			end
			PUSH_LO:
			begin
				xfer_addr = s_i - 16'h1;
				bus_write = 1'b1;
				xfer_wdata = pc_i[7:0];
			end
			PUSH_HI:
			begin
				xfer_addr = s_i - 16'h1; // S already stepped once
				bus_write = 1'b1;
				xfer_wdata = pc_i[15:8];
			end
			PULL_HI, PULL_LO: xfer_addr = s_i;
			DECODE, EXECUTE, BRANCH: bus_state = 1'b0;
			default: xfer_addr = pc_i;
		endcase
	end

	assign first_phase = bus_state && (phase_q == 2'd0);
	assign xfer_done = bus_state && (phase_q == 2'd2);

	always_comb
	begin
		case (state_q)
			VEC_HI: state_d = VEC_LO;
			VEC_LO: state_d = FETCH;
			FETCH: state_d = DECODE;
			DECODE:
			begin
				case (dec_i.mode)
					AM_IMMEDIATE, AM_RELATIVE: state_d = ARG_LO;
					AM_EXTENDED: state_d = ARG_HI;
					default: state_d = dec_i.is_rts ? PULL_HI : FETCH;
				endcase
				if (!dec_i.known)
					state_d = FETCH; // unknown opcode skipped
			end
			ARG_HI: state_d = ARG_LO;
			ARG_LO:
			begin
				if (dec_i.is_branch)
					state_d = BRANCH;
				else if (dec_i.reads_mem)
					state_d = MEM_READ;
				else if (dec_i.is_store)
					state_d = MEM_WRITE;
				else if (dec_i.is_jsr)
					state_d = PUSH_LO;
				else
					state_d = EXECUTE; // immediates and JMP
			end
			MEM_READ: state_d = EXECUTE;
			PUSH_LO: state_d = PUSH_HI;
			PULL_HI: state_d = PULL_LO;
			default: state_d = FETCH;
		endcase
	end

	always_comb
	begin
		reg_ctl_o = '0;
		reg_ctl_o.pc_inc = first_phase && (state_q inside {FETCH, ARG_HI, ARG_LO});
		reg_ctl_o.s_dec = first_phase && (state_q inside {PUSH_LO, PUSH_HI});
		reg_ctl_o.s_inc = first_phase && (state_q inside {PULL_HI, PULL_LO});
		reg_ctl_o.acc_write = (state_q == EXECUTE) && dec_i.writes_acc;
		reg_ctl_o.flag_write = (state_q == EXECUTE) && dec_i.writes_acc;
		reg_ctl_o.pc_load = (xfer_done && (state_q inside {VEC_LO, PUSH_HI, PULL_LO}))
			|| ((state_q == EXECUTE) && dec_i.is_jmp)
			|| ((state_q == BRANCH) && dec_i.branch_taken);
	end

	always_comb
	begin
		case (state_q)
			VEC_LO, PULL_LO: new_pc_o = {ea_hi_q, data_i}; // low byte straight off the bus
			BRANCH: new_pc_o = pc_i + {{8{operand_q[7]}}, operand_q};
			default: new_pc_o = {ea_hi_q, ea_lo_q};
		endcase
	end

	always_ff @(posedge cpu_clk_i or posedge k_reset_i)
	begin
		if (k_reset_i)
		begin
			state_q <= VEC_HI;
			phase_q <= 2'd0;
			re_q <= 1'b0;
			we_q <= 1'b0;
			addr_q <= RESET_VECTOR;
		end
		else
		begin
			re_q <= 1'b0; // strobes last one cycle
			we_q <= 1'b0;
			if (bus_state)
				phase_q <= xfer_done ? 2'd0 : phase_q + 2'd1;
			if (first_phase)
			begin
				addr_q <= xfer_addr;
				re_q <= !bus_write;
				we_q <= bus_write;
			end
			if (xfer_done || !bus_state)
				state_q <= state_d;
		end
	end

	always_ff @(posedge cpu_clk_i)
	begin
		if (first_phase)
			wdata_q <= xfer_wdata;
		if (xfer_done)
		begin
			case (state_q)
				FETCH: opcode_q <= data_i;
				VEC_HI, ARG_HI, PULL_HI: ea_hi_q <= data_i;
				ARG_LO:
				begin
					if (dec_i.mode == AM_EXTENDED)
						ea_lo_q <= data_i;
					else
						operand_q <= data_i; // immediate or branch offset
				end
				MEM_READ: operand_q <= data_i;
				default: ;
			endcase
		end
	end

	assign opcode_o = opcode_q;
	assign operand_o = operand_q;
	assign bus_o.addr = addr_q;
	assign bus_o.wdata = wdata_q;
	assign bus_o.we = we_q;
	assign bus_o.re = re_q;

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
// cpu_top: 8-bit accumulator core
// sequencer, decoder, ALU and register file
`timescale 1ns/1ps
`default_nettype none

module cpu_top
	import cpu_pkg::*;
#(
	parameter logic [15:0] STACK_INIT = 16'h0200
)
(
	input  wire        cpu_clk_i,
	input  wire        k_reset_i,
	input  wire [7:0]  data_i,
	output cpu_bus_t   bus_o,
	output logic [7:0] cc_o
);

	dec_ctl_t    dec_ctl;
	reg_ctl_t    reg_ctl;
	logic [7:0]  opcode;
	logic [7:0]  operand;
	logic [7:0]  acc;         // selected accumulator
	logic [7:0]  alu_result;
	logic [7:0]  alu_cc;
	logic [15:0] new_pc;
	logic [15:0] pc;
	logic [15:0] s;

	cpu_sequencer u_sequencer (
		.cpu_clk_i    (cpu_clk_i),
		.k_reset_i    (k_reset_i),
		.data_i       (data_i),
		.dec_i        (dec_ctl),
		.acc_i        (acc),
		.alu_result_i (alu_result),
		.pc_i         (pc),
		.s_i          (s),
		.opcode_o     (opcode),
		.operand_o    (operand),
		.reg_ctl_o    (reg_ctl),
		.new_pc_o     (new_pc),
		.bus_o        (bus_o)
	);

	cpu_decoder u_decoder (
		.opcode_i (opcode),
		.cc_i     (cc_o),
		.ctl_o    (dec_ctl)
	);

	cpu_alu u_alu (
		.op_i      (dec_ctl.alu_op),
		.acc_i     (acc),
		.operand_i (operand),
		.cc_i      (cc_o),
		.result_o  (alu_result),
		.cc_o      (alu_cc)
	);

	cpu_regfile #(
		.STACK_INIT (STACK_INIT)
	) u_regfile (
		.cpu_clk_i    (cpu_clk_i),
		.k_reset_i    (k_reset_i),
		.ctl_i        (reg_ctl),
		.acc_sel_i    (dec_ctl.acc_b),
		.alu_result_i (alu_result),
		.alu_cc_i     (alu_cc),
		.new_pc_i     (new_pc),
		.acc_o        (acc),
		.cc_o         (cc_o),
		.pc_o         (pc),
		.s_o          (s)
	);

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// tb_clock: clock and reset source for the core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 10,  // 20 ns period
	parameter int RESET_CYCLES = 3
)
(
	output logic cpu_clk_o,
	output logic k_reset_o
);

	initial
	begin
		cpu_clk_o = 1'b0;
		forever #(HALF_PERIOD) cpu_clk_o = ~cpu_clk_o;
	end

	initial
	begin
		k_reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge cpu_clk_o);
		k_reset_o <= 1'b0;  // released on a rising edge
	end

endmodule

`default_nettype wire

// ==== test/tb_memory.sv ====
// tb_memory: 64 KB byte memory on the core bus
// answers a read one cycle after the strobe and logs every write
`timescale 1ns/1ps
`default_nettype none

module tb_memory
	import cpu_pkg::*;
#(
	parameter int LOG_DEPTH = 64
)
(
	input  wire           cpu_clk_i,
	input  wire cpu_bus_t bus_i,
	output logic [7:0]    data_o
);

	logic [7:0]  mem [0:65535];
	logic [15:0] log_addr [0:LOG_DEPTH-1];
	logic [7:0]  log_data [0:LOG_DEPTH-1];
	int          log_count;

	initial
	begin
		for (int i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h3c;  // both address bytes in the pattern
		log_count = 0;
		data_o = 8'h00;
	end

	always @(posedge cpu_clk_i)
	begin
		if (bus_i.re)
			data_o <= mem[bus_i.addr];  // valid in the cycle after the strobe
		if (bus_i.we)
		begin
			mem[bus_i.addr] = bus_i.wdata;
			if (log_count < LOG_DEPTH)
			begin
				log_addr[log_count] = bus_i.addr;
				log_data[log_count] = bus_i.wdata;
			end
			log_count = log_count + 1;
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_cpu.sv ====
// tb_cpu: testbench top for the accumulator core
// builds one program in sections, then checks vector reads, stores and flags
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
	import cpu_pkg::*;
();

	localparam logic [15:0] STACK_INIT = 16'h0200;
	localparam logic [15:0] VECTOR_ADDR = 16'hfffe;
	localparam logic [15:0] START_ADDR = 16'h1000;
	localparam logic [15:0] SUB_ADDR = 16'h1200;
	localparam logic [15:0] JMP_ADDR = 16'h1300;
	localparam int WAIT_LIMIT = 400;  // cycles per wait

	wire       cpu_clk;
	wire       k_reset;
	wire [7:0] rd_data;
	wire [7:0] cc;
	cpu_bus_t  bus;

	logic [15:0] emit_pc;
	logic [7:0]  m_a;
	logic [7:0]  m_b;
	logic [7:0]  m_cc;  // expected flags
	int          build_test;
	logic [15:0] exp_addr [$];
	logic [7:0]  exp_data [$];
	logic [7:0]  exp_cc [$];
	int          exp_test [$];
	int          next_idx = 0;
	int          errors = 0;
	int          test_errors = 0;
	int          bus_faults = 0;
	int          tests_failed = 0;
	logic        aborted = 1'b0;

	tb_clock u_clock (
		.cpu_clk_o (cpu_clk),
		.k_reset_o (k_reset)
	);

	tb_memory u_mem (
		.cpu_clk_i (cpu_clk),
		.bus_i     (bus),
		.data_o    (rd_data)
	);

	cpu_top #(
		.STACK_INIT (STACK_INIT)
	) u_dut (
		.cpu_clk_i (cpu_clk),
		.k_reset_i (k_reset),
		.data_i    (rd_data),
		.bus_o     (bus),
		.cc_o      (cc)
	);

	task automatic bus_fault(input string what);
		$display("bus fault at %0t: %s", $time, what);
		bus_faults++;
	endtask

	a_no_overlap: assert property (@(posedge cpu_clk) !(bus.re && bus.we))
		else bus_fault("read and write strobes high together");
	a_read_pulse: assert property (@(posedge cpu_clk) bus.re |=> !bus.re)
		else bus_fault("read strobe high for more than one cycle");
	a_write_pulse: assert property (@(posedge cpu_clk) bus.we |=> !bus.we)
		else bus_fault("write strobe high for more than one cycle");
	a_reset_quiet: assert property (@(posedge cpu_clk) k_reset |-> !(bus.re || bus.we))
		else bus_fault("strobe active during reset");
	a_after_reset: assert property (@(posedge cpu_clk) k_reset |=> !(bus.re || bus.we))
		else bus_fault("strobe active right after reset");

	function automatic logic [7:0] make_cc(input logic [7:0] r, input logic v, input logic c);
		return {4'h0, r[7], r == 8'h00, v, c};
	endfunction

	function automatic logic overflows(input int value);
		return (value > 127) || (value < -128);
	endfunction

	// expected result of a load or ALU opcode, bit 6 picks B
	task automatic model_alu(input logic [7:0] opc, input logic [7:0] v);
		logic [7:0] x;
		logic [7:0] r;
		logic       c;
		logic       ov;
		x = opc[6] ? m_b : m_a;
		c = m_cc[FLAG_C];
		ov = 1'b0;
		case (opc[3:0])
			4'h6: r = v;
			4'hb:
			begin
				r = x + v;
				c = (int'(x) + int'(v)) > 255;
				ov = overflows(int'($signed(x)) + int'($signed(v)));
			end
			4'h0:
			begin
				r = x - v;
				c = v > x;  // borrow
				ov = overflows(int'($signed(x)) - int'($signed(v)));
			end
			4'h4: r = x & v;
			default: r = x ^ v;
		endcase
		if (opc[6])
			m_b = r;
		else
			m_a = r;
		m_cc = make_cc(r, ov, c);
	endtask

	task automatic emit(input logic [7:0] value);
		u_mem.mem[emit_pc] = value;
		emit_pc = emit_pc + 16'h1;
	endtask

	task automatic emit_ext(input logic [7:0] opc, input logic [15:0] addr);
		emit(opc);
		emit(addr[15:8]);
		emit(addr[7:0]);
	endtask

	task automatic alu_imm(input logic [7:0] opc, input logic [7:0] v);
		emit(opc);
		emit(v);
		model_alu(opc, v);
	endtask

	task automatic expect_write(input logic [15:0] addr, input logic [7:0] value);
		exp_addr.push_back(addr);
		exp_data.push_back(value);
		exp_cc.push_back(m_cc);
		exp_test.push_back(build_test);
	endtask

	task automatic store(input logic [7:0] opc, input logic [15:0] addr);
		emit_ext(opc, addr);
		expect_write(addr, opc[6] ? m_b : m_a);
	endtask

	task automatic branch_over_marker(input logic [7:0] opc, input logic [15:0] marker);
		logic taken;
		taken = (opc == OP_BRA) || ((opc == OP_BEQ) && m_cc[FLAG_Z])
			|| ((opc == OP_BNE) && !m_cc[FLAG_Z]);
		emit(opc);
		emit(8'h03);  // skips the 3-byte store
		emit_ext(OP_STA_EXT, marker);
		if (!taken)
			expect_write(marker, m_a);
	endtask

	task automatic build_program();
		logic [7:0]  seeded;
		logic [7:0]  seeded_b;
		logic [15:0] ret;
		m_a = 8'h00;
		m_b = 8'h00;
		m_cc = 8'h00;
		u_mem.mem[VECTOR_ADDR] = START_ADDR[15:8];
		u_mem.mem[VECTOR_ADDR + 16'h1] = START_ADDR[7:0];
		emit_pc = START_ADDR;
		build_test = 3;
		alu_imm(OP_LDA_IMM, 8'($urandom));
		alu_imm(OP_ADDA_IMM, 8'($urandom));
		store(OP_STA_EXT, 16'h0300);
		alu_imm(OP_SUBA_IMM, 8'($urandom));
		store(OP_STA_EXT, 16'h0301);
		alu_imm(OP_ANDA_IMM, 8'($urandom));
		store(OP_STA_EXT, 16'h0302);
		alu_imm(OP_EORA_IMM, 8'($urandom));
		store(OP_STA_EXT, 16'h0303);
		alu_imm(OP_LDB_IMM, 8'($urandom));
		alu_imm(OP_ADDB_IMM, 8'($urandom));
		store(OP_STB_EXT, 16'h0304);
		alu_imm(OP_SUBB_IMM, 8'($urandom));
		store(OP_STB_EXT, 16'h0305);
		alu_imm(OP_LDA_IMM, 8'h80);
		alu_imm(OP_ADDA_IMM, 8'h80);  // zero with carry out
		store(OP_STA_EXT, 16'h0306);
		build_test = 4;
		seeded = 8'($urandom);
		seeded_b = 8'($urandom);
		u_mem.mem[16'h0400] = seeded;
		u_mem.mem[16'h0401] = seeded_b;
		emit_ext(OP_LDA_EXT, 16'h0400);
		model_alu(OP_LDA_EXT, seeded);
		store(OP_STA_EXT, 16'h0310);
		emit_ext(OP_LDB_EXT, 16'h0401);
		model_alu(OP_LDB_EXT, seeded_b);
		store(OP_STB_EXT, 16'h0311);
		emit_ext(OP_ADDA_EXT, 16'h0401);
		model_alu(OP_ADDA_EXT, seeded_b);
		store(OP_STA_EXT, 16'h0312);
		build_test = 5;
		alu_imm(OP_LDA_IMM, 8'h00);
		branch_over_marker(OP_BEQ, 16'h0320);
		branch_over_marker(OP_BNE, 16'h0321);
		alu_imm(OP_LDA_IMM, 8'($urandom) | 8'h01);
		branch_over_marker(OP_BEQ, 16'h0322);
		branch_over_marker(OP_BNE, 16'h0323);
		branch_over_marker(OP_BRA, 16'h0324);
		store(OP_STA_EXT, 16'h0325);
		build_test = 6;
		emit(OP_NOP);
		emit(8'h01);  // not a known opcode
		emit_ext(OP_JSR, SUB_ADDR);
		ret = emit_pc;
		expect_write(STACK_INIT - 16'h1, ret[7:0]);
		expect_write(STACK_INIT - 16'h2, ret[15:8]);
		emit_pc = SUB_ADDR;
		alu_imm(OP_LDB_IMM, 8'($urandom));
		store(OP_STB_EXT, 16'h0330);
		emit(OP_RTS);
		emit_pc = ret;
		alu_imm(OP_LDA_IMM, 8'($urandom));
		store(OP_STA_EXT, 16'h0331);
		emit_ext(OP_JMP, JMP_ADDR);
		emit_pc = JMP_ADDR;
		store(OP_STB_EXT, 16'h0332);
		emit(OP_BRA);
		emit(8'hfe);  // parks the core here
	endtask

	task automatic time_out(input string what);
		$display("timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
		errors++;
		test_errors++;
		aborted = 1'b1;
	endtask

	task automatic check_value(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		if (!aborted)
		begin
			assert (got == exp)
			else
			begin
				$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
				errors++;
				test_errors++;
			end
		end
	endtask

	task automatic wait_read(output logic [15:0] addr);
		int n;
		n = 0;
		addr = 16'h0000;
		if (!aborted)
		begin
			do
			begin
				@(negedge cpu_clk);
				n++;
			end
			while (!bus.re && n < WAIT_LIMIT);
			if (bus.re)
				addr = bus.addr;
			else
				time_out("bus read");
		end
	endtask

	task automatic wait_write(input int idx);
		int n;
		n = 0;
		while (!aborted && u_mem.log_count <= idx && n < WAIT_LIMIT)
		begin
			@(negedge cpu_clk);
			n++;
		end
		if (!aborted && u_mem.log_count <= idx)
			time_out("bus write");
	endtask

	task automatic finish_test(input int t, input string name, input int checks);
		$display("test %0d %s: %0d checks, %0d errors", t, name, checks, test_errors);
		if (test_errors != 0)
			tests_failed++;
	endtask

	task automatic check_vector_reads();
		logic [15:0] addr;
		test_errors = 0;
		wait_read(addr);
		check_value("first read address", addr, VECTOR_ADDR);
		wait_read(addr);
		check_value("second read address", addr, VECTOR_ADDR + 16'h1);
		wait_read(addr);
		check_value("first opcode address", addr, START_ADDR);
		finish_test(1, "reset and vector", 3);
	endtask

	task automatic run_writes(input int t, input string name, input logic settle);
		int checks;
		checks = 0;
		test_errors = 0;
		while (next_idx < exp_addr.size() && exp_test[next_idx] == t)
		begin
			wait_write(next_idx);
			check_value("write address", u_mem.log_addr[next_idx], exp_addr[next_idx]);
			check_value("write data", 16'(u_mem.log_data[next_idx]), 16'(exp_data[next_idx]));
			check_value("flags", 16'(cc), 16'(exp_cc[next_idx]));
			checks++;
			next_idx++;
		end
		if (settle && !aborted)
		begin
			repeat (100) @(negedge cpu_clk);  // nothing more may be written
			check_value("write count", 16'(u_mem.log_count), 16'(exp_addr.size()));
		end
		finish_test(t, name, checks);
	endtask

	initial
	begin
		void'($urandom(32'h6eed_c1d4));
		@(negedge cpu_clk);  // after the memory fill, still in reset
		build_program();
		check_vector_reads();
		run_writes(3, "alu and flags", 1'b0);
		run_writes(4, "extended load and store", 1'b0);
		run_writes(5, "branches", 1'b0);
		run_writes(6, "subroutine and jump", 1'b1);
		$display("test 2 bus strobes: %0d violations", bus_faults);
		if (bus_faults != 0)
			tests_failed++;
		$display("tests run: 6, failed: %0d, errors: %0d", tests_failed, errors + bus_faults);
		if (errors == 0 && bus_faults == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/cpu_pkg.sv
rtl/cpu_alu.sv
rtl/cpu_decoder.sv
rtl/cpu_regfile.sv
rtl/cpu_sequencer.sv
rtl/cpu_top.sv
test/tb_clock.sv
test/tb_memory.sv
test/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build the core and its testbench with Verilator, run, and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_cpu -Mdir obj_dir
out=$(./obj_dir/Vtb_cpu || true)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS"
